// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = dataMmuTb
FILELIST = project.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir

// File: design/addrTranslate.sv
// ==================================================
// data address translation
// kseg0/kseg1 by base subtraction, mapped space
// through the translation buffer; gives the cache
// attribute, the request valid and the TLB
// exception class
// ==================================================
`timescale 1ns/10ps
`default_nettype none

module addrTranslate import mmuPkg::*; (
    input  vaddr_u            vaddr,
    input  logic [AsidW-1:0]  asid,
    input  logic              isLoad,
    input  logic              isStore,
    bufferView.consumer       view,
    output logic [VaddrW-1:0] paddr,
    output logic              cached,
    output logic              reqValid,
    output logic              refill,
    output logic              invalid,
    output logic              modified
);

    logic            unmapped;
    logic            isKseg1;
    logic [PfnW-1:0] pagePfn;
    logic [2:0]      pageAttr;
    logic            pageDirty;
    logic            pageValid;
    logic            asidOk;

    // segment decode on the top three bits
    assign unmapped = (vaddr.seg.top >= Kseg0Base[VaddrW-1 -: 3]) &&
                      (vaddr.seg.top <  Kseg2Base[VaddrW-1 -: 3]);
    assign isKseg1  = (vaddr.seg.top >= Kseg1Base[VaddrW-1 -: 3]);

    assign view.lookupReq = !unmapped;

    // even or odd half of the page pair
    always_comb begin
        if (vaddr.mapped.odd) begin
            pagePfn   = view.bufEntry.pfn1;
            pageAttr  = view.bufEntry.c1;
            pageDirty = view.bufEntry.d1;
            pageValid = view.bufEntry.v1;
        end else begin
            pagePfn   = view.bufEntry.pfn0;
            pageAttr  = view.bufEntry.c0;
            pageDirty = view.bufEntry.d0;
            pageValid = view.bufEntry.v0;
        end
    end

    always_comb begin
        if (unmapped) begin
            paddr  = vaddr - (isKseg1 ? Kseg1Base : Kseg0Base);
            cached = !isKseg1;                  // kseg1 is uncached
        end else begin
            paddr  = {pagePfn, vaddr.mapped.offset};
            cached = (pageAttr == CacheableAttr);
        end
    end

    assign asidOk = view.inTlb &&
                    (view.bufEntry.g || (view.bufEntry.asid == asid));

    always_comb begin
        reqValid = 1'b0;
        refill   = 1'b0;
        invalid  = 1'b0;
        modified = 1'b0;
        if (unmapped) begin
            reqValid = 1'b1;
        end else if (!view.hit) begin
            // refill sequence running, class not known yet
        end else if (!isLoad && !isStore) begin
            // no access this cycle
        end else if (asidOk) begin
            if (!pageValid) begin
                invalid = 1'b1;
            end else if (isStore && !pageDirty) begin
                modified = 1'b1;                // write to a clean page
            end else begin
                reqValid = 1'b1;
            end
        end else begin
            refill = 1'b1;      // not in the TLB for this asid
        end
    end

endmodule

`default_nettype wire

// File: design/dataMmu.sv
// ==================================================
// data MMU top
// joint TLB, one-entry buffer and translator
// behind plain CPU-side ports
// ==================================================
`timescale 1ns/10ps
`default_nettype none

module dataMmu import mmuPkg::*; #(
    parameter int  TlbEntries = 16,
    localparam int IdxW       = $clog2(TlbEntries)
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [VaddrW-1:0] vaddr,
    input  logic [AsidW-1:0]  asid,
    input  logic              isLoad,
    input  logic              isStore,
    input  logic              flush,       // drop the buffered page
    input  logic              tlbWe,
    input  logic [IdxW-1:0]   tlbIndex,
    input  logic [Vpn2W-1:0]  tlbVpn2,
    input  logic [AsidW-1:0]  tlbAsid,
    input  logic              tlbG,
    input  logic [PfnW-1:0]   tlbPfn0,
    input  logic [2:0]        tlbC0,
    input  logic              tlbD0,
    input  logic              tlbV0,
    input  logic [PfnW-1:0]   tlbPfn1,
    input  logic [2:0]        tlbC1,
    input  logic              tlbD1,
    input  logic              tlbV1,
    output logic [VaddrW-1:0] paddr,
    output logic              cached,
    output logic              reqValid,    // cache may start the access
    output logic              stall,
    output logic              refill,
    output logic              invalid,
    output logic              modified
);

    tlbEntry_t writeEntry;

    tlbSearchIf searchBus ();
    bufferView  bufView ();

    assign writeEntry = '{vpn2: tlbVpn2, asid: tlbAsid, g: tlbG,
                          pfn0: tlbPfn0, c0: tlbC0, d0: tlbD0, v0: tlbV0,
                          pfn1: tlbPfn1, c1: tlbC1, d1: tlbD1, v1: tlbV1};

    tlbArray #(
        .TlbEntries (TlbEntries)
    ) uTlbArray (
        .clk        (clk),
        .rst        (rst),
        .search     (searchBus),
        .writeEn    (tlbWe),
        .writeIndex (tlbIndex),
        .writeEntry (writeEntry)
    );

    microTlb uMicroTlb (
        .clk    (clk),
        .rst    (rst),
        .flush  (flush),
        .vaddr  (vaddr),
        .asid   (asid),
        .search (searchBus),
        .view   (bufView),
        .stall  (stall)
    );

    addrTranslate uAddrTranslate (
        .vaddr    (vaddr),
        .asid     (asid),
        .isLoad   (isLoad),
        .isStore  (isStore),
        .view     (bufView),
        .paddr    (paddr),
        .cached   (cached),
        .reqValid (reqValid),
        .refill   (refill),
        .invalid  (invalid),
        .modified (modified)
    );

endmodule

`default_nettype wire

// File: design/microTlb.sv
// ==================================================
// one-entry data translation buffer
// holds the last page pair fetched from the joint
// TLB; a miss runs a fixed idle -> search -> idle
// refill and stalls the pipeline meanwhile
// ==================================================
`timescale 1ns/10ps
`default_nettype none

module microTlb import mmuPkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             flush,
    input  vaddr_u           vaddr,
    input  logic [AsidW-1:0] asid,
    tlbSearchIf.requester    search,
    bufferView.provider      view,
    output logic             stall
);

    localparam logic Idle   = 1'b0;
    localparam logic Search = 1'b1;

    logic      state;
    logic      nextState;
    logic      bufLoad;
    logic      bufValid;    // an empty buffer never hits
    logic      bufInTlb;
    tlbEntry_t bufEntry;
    logic      hit;

    // search is driven straight from the current address
    assign search.vpn2 = vaddr.mapped.vpn2;
    assign search.asid = asid;

    assign hit   = bufValid && (bufEntry.vpn2 == vaddr.mapped.vpn2);
    assign stall = view.lookupReq && !hit;     // unmapped never stalls

    // one search cycle per miss, then back to idle
    always_comb begin
        nextState = Idle;
        if (state == Idle && stall) begin
            nextState = Search;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= Idle;
        end else begin
            state <= nextState;
        end
    end

    assign bufLoad = (state == Search);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            bufValid <= 1'b0;
        end else if (bufLoad) begin
            bufValid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bufInTlb <= 1'b0;
        end else if (bufLoad) begin
            bufInTlb <= search.found;   // only moves with the buffer
        end
    end

    // payload; tag comes from the address so a TLB miss still hits here
    always_ff @(posedge clk) begin
        if (bufLoad) begin
            bufEntry      <= search.entry;
            bufEntry.vpn2 <= vaddr.mapped.vpn2;
        end
    end

    assign view.hit      = hit;
    assign view.bufEntry = bufEntry;
    assign view.inTlb    = bufInTlb;

endmodule

`default_nettype wire

// File: design/mmuPkg.sv
// ==================================================
// data MMU package
// address widths, kernel segment bases, the joint
// TLB entry layout and the two views of a virtual
// data address
// ==================================================
`default_nettype none

package mmuPkg;

    localparam int VaddrW  = 32;        // virtual and physical
    localparam int Vpn2W   = 19;        // even/odd page pair number
    localparam int PfnW    = 20;
    localparam int AsidW   = 8;
    localparam int OffsetW = 12;        // 4 KiB pages

    localparam logic [2:0] CacheableAttr = 3'd3;    // cacheable, noncoherent

    // kseg1 base doubles as the end of kseg0
    localparam logic [VaddrW-1:0] Kseg0Base = 32'h8000_0000;
    localparam logic [VaddrW-1:0] Kseg1Base = 32'hA000_0000;
    localparam logic [VaddrW-1:0] Kseg2Base = 32'hC000_0000;   // end of kseg1

    // one joint TLB entry, one vpn2 covering an even and an odd page
    typedef struct packed {
        logic [Vpn2W-1:0] vpn2;
        logic [AsidW-1:0] asid;
        logic             g;            // global, ignores asid
        logic [PfnW-1:0]  pfn0;
        logic [2:0]       c0;
        logic             d0;           // dirty = writable
        logic             v0;
        logic [PfnW-1:0]  pfn1;
        logic [2:0]       c1;
        logic             d1;
        logic             v1;
    } tlbEntry_t;

    // same 32-bit word, seen as a mapped address or by segment
    typedef union packed {
        struct packed {
            logic [Vpn2W-1:0]   vpn2;
            logic               odd;    // selects pfn1 over pfn0
            logic [OffsetW-1:0] offset;
        } mapped;
        struct packed {
            logic [2:0]        top;     // kuseg / kseg0 / kseg1 / kseg2-3
            logic [VaddrW-4:0] rest;
        } seg;
    } vaddr_u;

endpackage

`default_nettype wire

// File: design/tlbArray.sv
// ==================================================
// joint TLB
// fully associative entries with one combinational
// search port and one indexed write port
// lowest matching index wins
// ==================================================
`timescale 1ns/10ps
`default_nettype none

module tlbArray import mmuPkg::*; #(
    parameter int  TlbEntries = 16,
    localparam int IdxW       = $clog2(TlbEntries)
) (
    input  logic            clk,
    input  logic            rst,
    tlbSearchIf.responder   search,
    input  logic            writeEn,
    input  logic [IdxW-1:0] writeIndex,
    input  tlbEntry_t       writeEntry
);

    tlbEntry_t             entries [TlbEntries];
    logic [TlbEntries-1:0] matchVec;

    // write port
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < TlbEntries; i++) begin
                entries[i] <= '0;
            end
        end else if (writeEn) begin
            entries[writeIndex] <= writeEntry;
        end
    end

    // vpn2 must match, asid only for non-global entries
    always_comb begin
        for (int i = 0; i < TlbEntries; i++) begin
            matchVec[i] = (entries[i].vpn2 == search.vpn2) &&
                          (entries[i].g || (entries[i].asid == search.asid));
        end
    end

    // scan downward so the lowest match is the one left standing
    always_comb begin
        search.found = |matchVec;
        search.entry = '0;
        for (int i = TlbEntries - 1; i >= 0; i--) begin
            if (matchVec[i]) begin
                search.entry = entries[i];
            end
        end
    end

endmodule

`default_nettype wire

// File: design/tlbSearchIf.sv
// ==================================================
// TLB search bundle and translation buffer view
// tlbSearchIf  buffer asks the joint TLB, which
//              answers in the same cycle
// bufferView   buffer contents toward the translator
// ==================================================
`timescale 1ns/10ps
`default_nettype none

interface tlbSearchIf import mmuPkg::*;;
    logic [Vpn2W-1:0] vpn2;
    logic [AsidW-1:0] asid;
    logic             found;
    tlbEntry_t        entry;

    modport requester (output vpn2, output asid, input found, input entry);
    modport responder (input vpn2, input asid, output found, output entry);
endinterface

interface bufferView import mmuPkg::*;;
    logic      lookupReq;       // address is mapped
    logic      hit;
    tlbEntry_t bufEntry;
    logic      inTlb;           // entry came from a real TLB match

    modport provider (input lookupReq, output hit, output bufEntry, output inTlb);
    modport consumer (output lookupReq, input hit, input bufEntry, input inTlb);
endinterface

`default_nettype wire

// File: project.f
design/mmuPkg.sv
design/tlbSearchIf.sv
design/tlbArray.sv
design/microTlb.sv
design/addrTranslate.sv
design/dataMmu.sv
sim/dataMmuChecker_checker.sv
sim/dataMmuMonitor.sv
sim/dataMmuTb.sv

// File: sim/dataMmuChecker_checker.sv
// ==================================================
// data MMU assertions, bound into dataMmu
// one exception at a time, no request beside an
// exception, refill stall ends two cycles after
// it rises
// ==================================================
`timescale 1ns/10ps
`default_nettype none

module dataMmuChecker import mmuPkg::*; (
    input logic              clk,
    input logic              rst,
    input logic [VaddrW-1:0] vaddr,
    input logic              stall,
    input logic              reqValid,
    input logic              refill,
    input logic              invalid,
    input logic              modified
);

    oneException: assert property (@(posedge clk) disable iff (rst)
        $onehot0({refill, invalid, modified}))
        else $error("more than one TLB exception flag high at once");

    noRequestOnException: assert property (@(posedge clk) disable iff (rst)
        !(reqValid && (refill || invalid || modified)))
        else $error("request valid together with a TLB exception");

    // judged only while the CPU holds the address
    stallEnds: assert property (@(posedge clk) disable iff (rst)
        $rose(stall) |-> ##2 (!stall || (vaddr != $past(vaddr)) ||
                              ($past(vaddr) != $past(vaddr, 2))))
        else $error("stall still high two cycles after it rose");

endmodule

bind dataMmu dataMmuChecker uChecker (
    .clk      (clk),
    .rst      (rst),
    .vaddr    (vaddr),
    .stall    (stall),
    .reqValid (reqValid),
    .refill   (refill),
    .invalid  (invalid),
    .modified (modified)
);

`default_nettype wire

// File: sim/dataMmuMonitor.sv
// ==================================================
// data MMU reference model and comparer
// shadow TLB from the write port, a model of the
// buffer fill timing, compare at mid-cycle
// ==================================================
`timescale 1ns/10ps
`default_nettype none

module dataMmuMonitor import mmuPkg::*; #(
    parameter int  TlbEntries = 16,
    localparam int IdxW       = $clog2(TlbEntries)
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [VaddrW-1:0] vaddr,
    input  logic [AsidW-1:0]  asid,
    input  logic              isLoad,
    input  logic              isStore,
    input  logic              flush,
    input  logic              tlbWe,
    input  logic [IdxW-1:0]   tlbIndex,
    input  logic [Vpn2W-1:0]  tlbVpn2,
    input  logic [AsidW-1:0]  tlbAsid,
    input  logic              tlbG,
    input  logic [PfnW-1:0]   tlbPfn0,
    input  logic [2:0]        tlbC0,
    input  logic              tlbD0,
    input  logic              tlbV0,
    input  logic [PfnW-1:0]   tlbPfn1,
    input  logic [2:0]        tlbC1,
    input  logic              tlbD1,
    input  logic              tlbV1,
    input  logic [VaddrW-1:0] paddr,
    input  logic              cached,
    input  logic              reqValid,
    input  logic              stall,
    input  logic              refill,
    input  logic              invalid,
    input  logic              modified,
    output int                errorCount,
    output int                checkCount
);

    tlbEntry_t        shadow [TlbEntries];
    logic             mValid;       // model of the buffer
    logic [Vpn2W-1:0] mVpn2;
    logic             seqBusy;      // refill search cycle under way
    logic             unmapped;
    logic [Vpn2W-1:0] addrVpn2;
    logic             expStall;

    assign unmapped = (vaddr >= Kseg0Base) && (vaddr < Kseg2Base);
    assign addrVpn2 = vaddr[VaddrW-1 -: Vpn2W];
    assign expStall = !unmapped && !(mValid && mVpn2 == addrVpn2);

    // lowest index wins, asid ignored for global entries
    function automatic logic findEntry(input logic [Vpn2W-1:0] vpn2,
                                       input logic [AsidW-1:0] id,
                                       output tlbEntry_t match);
        logic found;
        found = 1'b0;
        match = '0;
        for (int i = 0; i < TlbEntries; i++) begin
            if (!found && shadow[i].vpn2 == vpn2 && (shadow[i].g || shadow[i].asid == id)) begin
                found = 1'b1;
                match = shadow[i];
            end
        end
        return found;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("Error %s: expected %h, actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < TlbEntries; i++) begin
                shadow[i] <= '0;
            end
            mValid  <= 1'b0;
            seqBusy <= 1'b0;
        end else begin
            if (tlbWe) begin
                shadow[tlbIndex] <= '{vpn2: tlbVpn2, asid: tlbAsid, g: tlbG,
                                      pfn0: tlbPfn0, c0: tlbC0, d0: tlbD0, v0: tlbV0,
                                      pfn1: tlbPfn1, c1: tlbC1, d1: tlbD1, v1: tlbV1};
            end
            seqBusy <= !seqBusy && expStall;   // miss, one search cycle
            if (flush) begin
                mValid <= 1'b0;
            end else if (seqBusy) begin
                mValid <= 1'b1;
                mVpn2  <= addrVpn2;
            end
        end
    end

    always @(negedge clk) begin
        tlbEntry_t       e;
        logic            found;
        logic [PfnW-1:0] pagePfn;
        logic [2:0]      pageC;
        logic            pageD;
        logic            pageV;
        logic [3:0]      expFlags;     // reqValid refill invalid modified
        if (rst) begin
            errorCount = 0;
            checkCount = 0;
        end else begin
            checkValue("stall", expStall, stall);
            if (!stall) begin
                found    = findEntry(addrVpn2, asid, e);
                pagePfn  = vaddr[OffsetW] ? e.pfn1 : e.pfn0;
                pageC    = vaddr[OffsetW] ? e.c1 : e.c0;
                pageD    = vaddr[OffsetW] ? e.d1 : e.d0;
                pageV    = vaddr[OffsetW] ? e.v1 : e.v0;
                expFlags = 4'b0000;
                if (unmapped) begin
                    expFlags = 4'b1000;
                    checkValue("unmapped paddr",
                               vaddr - ((vaddr >= Kseg1Base) ? Kseg1Base : Kseg0Base), paddr);
                    checkValue("unmapped cached", vaddr < Kseg1Base, cached);
                end else begin
                    if (found) begin
                        checkValue("mapped paddr", {pagePfn, vaddr[OffsetW-1:0]}, paddr);
                        checkValue("mapped cached", pageC == CacheableAttr, cached);
                    end
                    if (isLoad || isStore) begin
                        if (!found) begin
                            expFlags = 4'b0100;
                        end else if (!pageV) begin
                            expFlags = 4'b0010;
                        end else if (isStore && !pageD) begin
                            expFlags = 4'b0001;    // store to a clean page
                        end else begin
                            expFlags = 4'b1000;
                        end
                    end
                end
                checkValue("request and exception flags", expFlags,
                           {reqValid, refill, invalid, modified});
            end
        end
    end

endmodule

`default_nettype wire

// File: sim/dataMmuTb.sv
// ==================================================
// data MMU testbench
// random TLB writes, asid changes and loads/stores
// from an xorshift stream, address held through
// every stall, results judged by dataMmuMonitor
// ==================================================
`timescale 1ns/10ps
`default_nettype none

module dataMmuTb import mmuPkg::*; ;

    localparam int TlbEntries = 16;
    localparam int IdxW       = $clog2(TlbEntries);
    localparam int NumOps     = 600;
    localparam int StallLimit = 8;     // cycles

    logic              clk;
    logic              rst;
    logic [VaddrW-1:0] vaddr;
    logic [AsidW-1:0]  asid;
    logic              isLoad;
    logic              isStore;
    logic              flush;
    logic              tlbWe;
    logic [IdxW-1:0]   tlbIndex;
    logic [Vpn2W-1:0]  tlbVpn2;
    logic [AsidW-1:0]  tlbAsid;
    logic              tlbG;
    logic [PfnW-1:0]   tlbPfn0;
    logic [2:0]        tlbC0;
    logic              tlbD0;
    logic              tlbV0;
    logic [PfnW-1:0]   tlbPfn1;
    logic [2:0]        tlbC1;
    logic              tlbD1;
    logic              tlbV1;
    logic [VaddrW-1:0] paddr;
    logic              cached;
    logic              reqValid;
    logic              stall;
    logic              refill;
    logic              invalid;
    logic              modified;

    int          errorCount;
    int          checkCount;
    logic        timedOut;
    logic [31:0] rngState;

    dataMmu #(
        .TlbEntries (TlbEntries)
    ) UUT (
        .clk (clk), .rst (rst), .vaddr (vaddr), .asid (asid),
        .isLoad (isLoad), .isStore (isStore), .flush (flush),
        .tlbWe (tlbWe), .tlbIndex (tlbIndex), .tlbVpn2 (tlbVpn2),
        .tlbAsid (tlbAsid), .tlbG (tlbG),
        .tlbPfn0 (tlbPfn0), .tlbC0 (tlbC0), .tlbD0 (tlbD0), .tlbV0 (tlbV0),
        .tlbPfn1 (tlbPfn1), .tlbC1 (tlbC1), .tlbD1 (tlbD1), .tlbV1 (tlbV1),
        .paddr (paddr), .cached (cached), .reqValid (reqValid),
        .stall (stall), .refill (refill), .invalid (invalid),
        .modified (modified)
    );

    dataMmuMonitor #(
        .TlbEntries (TlbEntries)
    ) uMonitor (
        .clk (clk), .rst (rst), .vaddr (vaddr), .asid (asid),
        .isLoad (isLoad), .isStore (isStore), .flush (flush),
        .tlbWe (tlbWe), .tlbIndex (tlbIndex), .tlbVpn2 (tlbVpn2),
        .tlbAsid (tlbAsid), .tlbG (tlbG),
        .tlbPfn0 (tlbPfn0), .tlbC0 (tlbC0), .tlbD0 (tlbD0), .tlbV0 (tlbV0),
        .tlbPfn1 (tlbPfn1), .tlbC1 (tlbC1), .tlbD1 (tlbD1), .tlbV1 (tlbV1),
        .paddr (paddr), .cached (cached), .reqValid (reqValid),
        .stall (stall), .refill (refill), .invalid (invalid),
        .modified (modified),
        .errorCount (errorCount),
        .checkCount (checkCount)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] nextRand();
        rngState = xorshift32(rngState);
        return rngState;
    endfunction

    // small page pool so the buffer and the TLB see repeats
    function automatic logic [Vpn2W-1:0] poolVpn2(input logic [1:0] sel);
        case (sel)
            2'd0:    return 19'h00012;
            2'd1:    return 19'h0ABCD;
            2'd2:    return 19'h60010;     // kseg2
            default: return 19'h7FFF0;     // kseg3
        endcase
    endfunction

    task automatic holdWhileStalled();
        int waited;
        waited = 0;
        @(negedge clk);
        while (stall && waited < StallLimit) begin
            @(negedge clk);
            waited++;
        end
        if (stall) begin
            $display("timeout: stall still high %0d cycles into a held access", waited + 1);
            timedOut = 1'b1;
        end
    endtask

    task automatic accessAt(input logic [VaddrW-1:0] addr);
        logic [31:0] r;
        r = nextRand();
        @(posedge clk);
        vaddr   <= addr;
        isLoad  <= r[0];
        isStore <= r[1];       // both low now and then, no access
        tlbWe   <= 1'b0;
        flush   <= 1'b0;
        holdWhileStalled();
    endtask

    task automatic randomAccess();
        logic [31:0]       r;
        logic [VaddrW-1:0] addr;
        r = nextRand();
        case (r[2:0])
            3'd0:    addr = Kseg0Base + {3'b000, r[31:3]};
            3'd1:    addr = Kseg1Base + {3'b000, r[31:3]};
            default: addr = {poolVpn2(r[4:3]), r[17:5]};   // odd bit and offset
        endcase
        accessAt(addr);
    endtask

    // write cycle, flush cycle, then a look at the page just written
    task automatic writeAndAccess();
        logic [31:0] r;
        logic [31:0] s;
        r = nextRand();
        s = nextRand();
        @(posedge clk);
        vaddr    <= Kseg1Base;
        isLoad   <= 1'b0;
        isStore  <= 1'b0;
        flush    <= 1'b0;
        tlbWe    <= 1'b1;
        tlbIndex <= r[3:0];
        tlbVpn2  <= poolVpn2(r[5:4]);
        tlbAsid  <= {6'd0, r[7:6]};
        tlbG     <= (r[9:8] == 2'd0);
        tlbPfn0  <= s[19:0];
        tlbC0    <= r[12:10];
        tlbD0    <= r[13];
        tlbV0    <= (r[15:14] != 2'd0);
        tlbPfn1  <= {s[31:20], s[7:0]};
        tlbC1    <= r[18:16];
        tlbD1    <= r[19];
        tlbV1    <= (r[21:20] != 2'd0);
        @(posedge clk);
        tlbWe <= 1'b0;
        flush <= 1'b1;
        accessAt({poolVpn2(r[5:4]), r[30:18]});
    endtask

    task automatic changeAsid();
        logic [31:0] r;
        r = nextRand();
        @(posedge clk);
        vaddr   <= Kseg0Base;
        isLoad  <= 1'b0;
        isStore <= 1'b0;
        tlbWe   <= 1'b0;
        flush   <= 1'b0;
        asid    <= {6'd0, r[1:0]};
        @(posedge clk);
        flush <= 1'b1;          // cleared by the next operation
    endtask

    initial begin
        int          op;
        logic [31:0] r;
        rngState = 32'he192_0dba;
        timedOut = 1'b0;
        rst      = 1'b1;
        vaddr    = Kseg0Base;   // unmapped, so no stall during reset
        asid     = '0;
        isLoad   = 1'b0;
        isStore  = 1'b0;
        flush    = 1'b0;
        tlbWe    = 1'b0;
        tlbIndex = '0;
        tlbVpn2  = '0;
        tlbAsid  = '0;
        tlbG     = 1'b0;
        tlbPfn0  = '0;
        tlbC0    = '0;
        tlbD0    = 1'b0;
        tlbV0    = 1'b0;
        tlbPfn1  = '0;
        tlbC1    = '0;
        tlbD1    = 1'b0;
        tlbV1    = 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        op = 0;
        while (op < NumOps && !timedOut) begin
            r = nextRand();
            case (r % 10)
                0:       writeAndAccess();
                1:       changeAsid();
                default: randomAccess();
            endcase
            op++;
        end

        @(posedge clk);         // monitor finishes its last compare
        $display("checks %0d, errors %0d, timeout %0d", checkCount, errorCount, timedOut);
        if (errorCount == 0 && !timedOut) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
